//--- source/stream_pkg.sv
package stream_pkg;

	// default width of the stream payload and of the host push and pop words.
	parameter int DEFAULT_DATA_WIDTH = 32;

	// number of beats that make up one packet on the stream.
	parameter int DEFAULT_BURST_LEN = 16;

	// entries in each FIFO. This has to be at least twice the burst length.
	parameter int DEFAULT_FIFO_DEPTH = 32;

	// cycles the master waits after reset before it may send.
	parameter int DEFAULT_START_COUNT = 1;

	// the stream master first counts out its start delay. It then waits in idle
	// until one whole burst sits in its FIFO and sends it.
	typedef enum logic [1:0] {
		mst_start_wait,
		mst_idle,
		mst_send
	} master_state_t;

endpackage

//--- source/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo import stream_pkg::*; #(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
	input  logic                            m00_axis_aclk,
	input  logic                            rst,
	input  logic                            wr_en,
	input  logic [DATA_WIDTH-1:0]           wr_data,
	input  logic                            rd_en,
	output logic [DATA_WIDTH-1:0]           rd_data,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count,
	output logic                            full,
	output logic                            empty,
	output logic                            error_full,
	output logic                            error_empty
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	// pointers wrap at the depth, so the depth need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge m00_axis_aclk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// the popped word is registered and stays on rd_data until the next pop.
	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			rd_data     <= '0;
			error_full  <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr  <= next_ptr(rd_ptr);
				rd_data <= mem[rd_ptr];
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr_en && full) begin
				error_full <= 1'b1;
			end
			if (rd_en && empty) begin
				error_empty <= 1'b1;
			end
		end
	end

endmodule

//--- source/axis_burst_master.sv
`timescale 1ns/1ns

module axis_burst_master import stream_pkg::*; #(
	parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
	parameter int BURST_LEN   = DEFAULT_BURST_LEN,
	parameter int FIFO_DEPTH  = DEFAULT_FIFO_DEPTH,
	parameter int START_COUNT = DEFAULT_START_COUNT
) (
	input  logic                      m00_axis_aclk,
	input  logic                      rst,
	input  logic                      wen,
	input  logic [DATA_WIDTH-1:0]     wdata,
	input  logic                      m00_axis_tready,
	output logic                      error_full,
	output logic                      error_empty,
	output logic                      m00_axis_tvalid,
	output logic [DATA_WIDTH-1:0]     m00_axis_tdata,
	output logic [DATA_WIDTH/8-1:0]   m00_axis_tstrb,
	output logic                      m00_axis_tlast
);

	localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
	localparam int BEAT_W  = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	localparam int START_W = (START_COUNT > 1) ? $clog2(START_COUNT) : 1;

	master_state_t      state;
	logic [START_W-1:0] start_cnt;
	logic [BEAT_W-1:0]  beat_cnt;
	logic [CNT_W-1:0]   tx_count;
	logic               burst_avail;
	logic               beat_done;
	logic               last_beat;
	logic               fifo_rd;

	assign burst_avail = (tx_count >= CNT_W'(BURST_LEN));
	assign last_beat   = (beat_cnt == BEAT_W'(BURST_LEN - 1));
	assign beat_done   = m00_axis_tvalid && m00_axis_tready;

	// the first word is popped on the edge that enters mst_send, and each
	// accepted beat but the last pops the next one. The FIFO read register
	// therefore always holds the beat on offer and keeps it under back-pressure.
	assign fifo_rd = ((state == mst_idle) && burst_avail) || (beat_done && !last_beat);

	assign m00_axis_tvalid = (state == mst_send);
	assign m00_axis_tlast  = (state == mst_send) && last_beat;
	assign m00_axis_tstrb  = '1;

	sync_fifo #(
		.DATA_WIDTH(DATA_WIDTH),
		.FIFO_DEPTH(FIFO_DEPTH)
	) tx_fifo (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.wr_en(wen),
		.wr_data(wdata),
		.rd_en(fifo_rd),
		.rd_data(m00_axis_tdata),
		.count(tx_count),
		.full(),
		.empty(),
		.error_full(error_full),
		.error_empty(error_empty)
	);

	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			state     <= mst_start_wait;
			start_cnt <= '0;
			beat_cnt  <= '0;
		end else begin
			case (state)
				mst_start_wait: begin
					if (start_cnt == START_W'(START_COUNT - 1)) begin
						state <= mst_idle;
					end else begin
						start_cnt <= start_cnt + 1'b1;
					end
				end
				mst_idle: begin
					beat_cnt <= '0;
					if (burst_avail) begin
						state <= mst_send;
					end
				end
				mst_send: begin
					if (beat_done) begin
						if (last_beat) begin
							state    <= mst_idle;
							beat_cnt <= '0;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
				default: state <= mst_idle;
			endcase
		end
	end

endmodule

//--- source/axis_burst_slave.sv
`timescale 1ns/1ns

module axis_burst_slave import stream_pkg::*; #(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int BURST_LEN  = DEFAULT_BURST_LEN,
	parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
	input  logic                    m00_axis_aclk,
	input  logic                    rst,
	input  logic                    ren,
	input  logic                    m00_axis_tvalid,
	input  logic [DATA_WIDTH-1:0]   m00_axis_tdata,
	input  logic [DATA_WIDTH/8-1:0] m00_axis_tstrb,
	input  logic                    m00_axis_tlast,
	output logic [DATA_WIDTH-1:0]   rdata,
	output logic                    r_ready,
	output logic                    error_full,
	output logic                    error_empty,
	output logic                    error_framing,
	output logic                    m00_axis_tready
);

	localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
	localparam int BEAT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	logic [DATA_WIDTH-1:0] beat_data;
	logic [BEAT_W-1:0]     beat_pos;
	logic [CNT_W-1:0]      rx_count;
	logic                  fifo_full;
	logic                  accept;
	logic                  burst_end;

	// beats are taken whenever the receive FIFO has room for one more word.
	assign m00_axis_tready = !fifo_full;
	assign accept          = m00_axis_tvalid && m00_axis_tready;
	assign burst_end       = (beat_pos == BEAT_W'(BURST_LEN - 1));
	assign r_ready         = (rx_count >= CNT_W'(BURST_LEN));

	// bytes whose strobe is low are position bytes and are stored as zero.
	always_comb begin
		for (int b = 0; b < DATA_WIDTH / 8; b++) begin
			beat_data[b*8 +: 8] = m00_axis_tstrb[b] ? m00_axis_tdata[b*8 +: 8] : 8'h00;
		end
	end

	sync_fifo #(
		.DATA_WIDTH(DATA_WIDTH),
		.FIFO_DEPTH(FIFO_DEPTH)
	) rx_fifo (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.wr_en(accept),
		.wr_data(beat_data),
		.rd_en(ren),
		.rd_data(rdata),
		.count(rx_count),
		.full(fifo_full),
		.empty(),
		.error_full(error_full),
		.error_empty(error_empty)
	);

	// the position counter runs over every accepted beat, so tlast must land
	// exactly on each BURST_LEN-th beat.
	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			beat_pos      <= '0;
			error_framing <= 1'b0;
		end else if (accept) begin
			if (burst_end) begin
				beat_pos <= '0;
			end else begin
				beat_pos <= beat_pos + 1'b1;
			end
			if (m00_axis_tlast != burst_end) begin
				error_framing <= 1'b1;
			end
		end
	end

endmodule

//--- source/stream_loop_top.sv
`timescale 1ns/1ns

module stream_loop_top import stream_pkg::*; #(
	parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
	parameter int BURST_LEN   = DEFAULT_BURST_LEN,
	parameter int FIFO_DEPTH  = DEFAULT_FIFO_DEPTH,
	parameter int START_COUNT = DEFAULT_START_COUNT
) (
	input  logic                  m00_axis_aclk,
	input  logic                  rst,
	input  logic                  wen,
	input  logic [DATA_WIDTH-1:0] wdata,
	output logic                  error_full_tx,
	output logic                  error_empty_tx,
	input  logic                  ren,
	output logic [DATA_WIDTH-1:0] rdata,
	output logic                  r_ready,
	output logic                  error_full_rx,
	output logic                  error_empty_rx,
	output logic                  error_framing
);

	logic                    m00_axis_tvalid;
	logic [DATA_WIDTH-1:0]   m00_axis_tdata;
	logic [DATA_WIDTH/8-1:0] m00_axis_tstrb;
	logic                    m00_axis_tlast;
	logic                    m00_axis_tready;

	axis_burst_master #(
		.DATA_WIDTH(DATA_WIDTH),
		.BURST_LEN(BURST_LEN),
		.FIFO_DEPTH(FIFO_DEPTH),
		.START_COUNT(START_COUNT)
	) master (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.wen(wen),
		.wdata(wdata),
		.m00_axis_tready(m00_axis_tready),
		.error_full(error_full_tx),
		.error_empty(error_empty_tx),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tdata(m00_axis_tdata),
		.m00_axis_tstrb(m00_axis_tstrb),
		.m00_axis_tlast(m00_axis_tlast)
	);

	axis_burst_slave #(
		.DATA_WIDTH(DATA_WIDTH),
		.BURST_LEN(BURST_LEN),
		.FIFO_DEPTH(FIFO_DEPTH)
	) slave (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.ren(ren),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tdata(m00_axis_tdata),
		.m00_axis_tstrb(m00_axis_tstrb),
		.m00_axis_tlast(m00_axis_tlast),
		.rdata(rdata),
		.r_ready(r_ready),
		.error_full(error_full_rx),
		.error_empty(error_empty_rx),
		.error_framing(error_framing),
		.m00_axis_tready(m00_axis_tready)
	);

endmodule

//--- testbench/stream_loop_tb.sv
`timescale 1ns/1ns

module stream_loop_tb import stream_pkg::*; ();

	localparam int DATA_WIDTH      = DEFAULT_DATA_WIDTH;
	localparam int BURST_LEN       = 16;
	localparam int FIFO_DEPTH      = DEFAULT_FIFO_DEPTH;
	localparam int START_COUNT     = DEFAULT_START_COUNT;
	// with nothing popped the loop holds both FIFOs plus the beat on offer.
	localparam int SYSTEM_CAP      = 2 * FIFO_DEPTH + 1;
	localparam int CYCLES_PER_LINE = 200;

	logic                  m00_axis_aclk;
	logic                  rst;
	logic                  wen;
	logic [DATA_WIDTH-1:0] wdata;
	logic                  ren;
	logic [DATA_WIDTH-1:0] rdata;
	logic                  r_ready;
	logic                  error_full_tx;
	logic                  error_empty_tx;
	logic                  error_full_rx;
	logic                  error_empty_rx;
	logic                  error_framing;

	logic [DATA_WIDTH-1:0] model_q[$];
	byte                   op_list[$];
	logic [31:0]           arg_list[$];
	int                    data_errors;
	int                    flag_errors;
	int                    other_errors;
	int                    cycles;
	int                    cycle_limit;
	master_state_t         stuck_state;

	stream_loop_top #(
		.DATA_WIDTH(DATA_WIDTH),
		.BURST_LEN(BURST_LEN),
		.FIFO_DEPTH(FIFO_DEPTH),
		.START_COUNT(START_COUNT)
	) dut (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.wen(wen),
		.wdata(wdata),
		.error_full_tx(error_full_tx),
		.error_empty_tx(error_empty_tx),
		.ren(ren),
		.rdata(rdata),
		.r_ready(r_ready),
		.error_full_rx(error_full_rx),
		.error_empty_rx(error_empty_rx),
		.error_framing(error_framing)
	);

	always #4 m00_axis_aclk = ~m00_axis_aclk;

	always @(posedge m00_axis_aclk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			stuck_state = dut.master.state;
			$display("timeout: the run stopped waiting after %0d cycles, master in %s",
				cycles, stuck_state.name());
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
			input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			data_errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag_vector(input logic [31:0] expected);
		@(negedge m00_axis_aclk);
		check_flag("r_ready", expected[5], r_ready);
		check_flag("error_framing", expected[4], error_framing);
		check_flag("error_empty_rx", expected[3], error_empty_rx);
		check_flag("error_full_rx", expected[2], error_full_rx);
		check_flag("error_empty_tx", expected[1], error_empty_tx);
		check_flag("error_full_tx", expected[0], error_full_tx);
	endtask

	task automatic apply_reset();
		rst   = 1'b1;
		wen   = 1'b0;
		ren   = 1'b0;
		wdata = '0;
		repeat (4) @(negedge m00_axis_aclk);
		rst = 1'b0;
		model_q.delete();
	endtask

	task automatic push_word(input logic [DATA_WIDTH-1:0] word);
		int unsigned gap;
		gap = $urandom % 3;
		repeat (gap) @(negedge m00_axis_aclk);
		@(negedge m00_axis_aclk);
		wen   = 1'b1;
		wdata = word;
		@(negedge m00_axis_aclk);
		wen = 1'b0;
		// once the loop is full the transmit FIFO drops the word.
		if (model_q.size() < SYSTEM_CAP) begin
			model_q.push_back(word);
		end
	endtask

	task automatic pop_word(output logic [DATA_WIDTH-1:0] word);
		@(negedge m00_axis_aclk);
		ren = 1'b1;
		@(negedge m00_axis_aclk);
		ren  = 1'b0;
		word = rdata;
	endtask

	task automatic pop_burst();
		logic [DATA_WIDTH-1:0] expected;
		logic [DATA_WIDTH-1:0] actual;
		for (int i = 0; i < BURST_LEN; i++) begin
			if (model_q.size() == 0) begin
				other_errors++;
				$display("the model has no word left to expect for a burst pop");
				return;
			end
			expected = model_q.pop_front();
			pop_word(actual);
			check_data("rdata", expected, actual);
		end
	endtask

	task automatic wait_ready();
		@(negedge m00_axis_aclk);
		while (!r_ready) begin
			@(negedge m00_axis_aclk);
		end
	endtask

	task automatic read_patterns();
		int          fd;
		int          fields;
		string       line;
		string       op_str;
		logic [31:0] arg;
		fd = $fopen("testbench/stream_loop_patterns.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the pattern file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%s %h", op_str, arg);
				if (fields == 2 && op_str.getc(0) != "#") begin
					op_list.push_back(op_str.getc(0));
					arg_list.push_back(arg);
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		logic [DATA_WIDTH-1:0] word;
		logic [DATA_WIDTH-1:0] actual;
		m00_axis_aclk = 1'b0;
		rst           = 1'b1;
		wen           = 1'b0;
		ren           = 1'b0;
		wdata         = '0;
		data_errors   = 0;
		flag_errors   = 0;
		other_errors  = 0;
		cycles        = 0;
		cycle_limit   = 0;
		void'($urandom(38));
		read_patterns();
		cycle_limit = CYCLES_PER_LINE * op_list.size();
		apply_reset();
		for (int k = 0; k < op_list.size(); k++) begin
			case (op_list[k])
				"W": push_word(arg_list[k]);
				"B": begin
					for (int i = 0; i < int'(arg_list[k]); i++) begin
						word = $urandom;
						push_word(word);
					end
				end
				"R": begin
					pop_word(actual);
					check_data("rdata", arg_list[k], actual);
					if (model_q.size() > 0) begin
						word = model_q.pop_front();
					end
				end
				"Q": pop_burst();
				"A": wait_ready();
				"I": repeat (arg_list[k]) @(negedge m00_axis_aclk);
				"F": check_flag_vector(arg_list[k]);
				"X": apply_reset();
				default: begin
					other_errors++;
					$display("unknown opcode on pattern line %0d", k);
				end
			endcase
		end
		$display("errors: %0d data, %0d flag, %0d other", data_errors, flag_errors,
			other_errors);
		if (data_errors + flag_errors + other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- testbench/stream_loop_patterns.txt
# columns: opcode, operand in hex. W push, B push n random, R pop and expect, Q pop a burst,
# A wait r_ready, I idle n cycles, F expect flags, X reset.
# F bits: 5 r_ready, 4 error_framing, 3 error_empty_rx, 2 error_full_rx, 1 error_empty_tx, 0 error_full_tx
W a0a00000
W a0a00001
W a0a00002
W a0a00003
W a0a00004
W a0a00005
W a0a00006
W a0a00007
W a0a00008
W a0a00009
W a0a0000a
W a0a0000b
W a0a0000c
W a0a0000d
W a0a0000e
W a0a0000f
A 0
Q 0
F 0
B f
I 64
F 0
W 5a5a0f0f
A 0
F 20
Q 0
F 0
B 10
B 10
B 10
I 64
F 20
A 0
Q 0
A 0
Q 0
A 0
Q 0
F 0
B 10
B 10
B 10
B 10
W 3c3c1234
I 10
F 20
W dead0001
W dead0002
W dead0003
F 21
A 0
Q 0
A 0
Q 0
A 0
Q 0
A 0
Q 0
B e
W 7e7e4321
A 0
Q 0
R 7e7e4321
F 9
X 0
F 0
B 10
A 0
Q 0
F 0

//--- sources.f
source/stream_pkg.sv
source/sync_fifo.sv
source/axis_burst_master.sv
source/axis_burst_slave.sv
source/stream_loop_top.sv
testbench/stream_loop_tb.sv

//--- Makefile
# Verilator build and run of the stream loopback testbench.

VERILATOR ?= verilator
TOP       ?= stream_loop_tb
FLAGS     ?= --binary -j 0
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR, TOP, FLAGS, FILELIST, OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -e "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
